// File: rtl/perfPkg.sv
package perfPkg;

    // Every event counter wraps modulo 2^32
    typedef logic [31:0] counterT;

    // Readout address, eight slots with six mapped
    typedef logic [2:0] perfAddrT;

    localparam perfAddrT AddrTotalBranches = 3'd0;  // All executed branches
    localparam perfAddrT AddrMispredicted  = 3'd1;  // Executed and mispredicted
    localparam perfAddrT AddrCacheMiss     = 3'd2;
    localparam perfAddrT AddrCacheAccess   = 3'd3;  // One per access start
    localparam perfAddrT AddrCacheTimer    = 3'd4;  // Busy cycles
    localparam perfAddrT AddrCacheHit      = 3'd5;  // Derived, accesses minus misses

    // Slots 6 and 7 are left unmapped and read back as zero

    // Cache busy tracking
    typedef enum logic {
        Idle,
        Counting
    } cacheStateT;

endpackage

// File: rtl/perfEventCapture.sv
`timescale 1ns/10ps

module perfEventCapture (
    input  logic clk,
    input  logic rst,
    input  logic branchExecuted,
    input  logic branchMispredict,
    input  logic cacheMiss,
    input  logic cacheStart,
    input  logic cacheEnd,
    input  logic countEnable,
    input  logic clear,
    output logic evBranchExec,
    output logic evBranchMiss,
    output logic evCacheMiss,
    output logic evCacheStart,
    output logic evCacheEnd,
    output logic clearCounts
);

    logic branchExecReg;
    logic branchMissReg;
    logic cacheMissReg;
    logic cacheStartReg;
    logic cacheEndReg;
    logic enableReg;  // Enable sampled with the strobes
    logic clearReg;

    // One register stage between the core and the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            branchExecReg <= 1'b0;
            branchMissReg <= 1'b0;
            cacheMissReg  <= 1'b0;
            cacheStartReg <= 1'b0;
            cacheEndReg   <= 1'b0;
            enableReg     <= 1'b0;
            clearReg      <= 1'b0;
        end else begin
            branchExecReg <= branchExecuted;
            branchMissReg <= branchMispredict;
            cacheMissReg  <= cacheMiss;
            cacheStartReg <= cacheStart;
            cacheEndReg   <= cacheEnd;
            enableReg     <= countEnable;
            clearReg      <= clear;
        end
    end

    // Events only pass while counting was enabled in the same cycle
    assign evBranchExec = branchExecReg & enableReg;
    assign evBranchMiss = branchMissReg & enableReg;
    assign evCacheMiss  = cacheMissReg & enableReg;
    assign evCacheStart = cacheStartReg & enableReg;
    assign evCacheEnd   = cacheEndReg & enableReg;

    assign clearCounts = clearReg;  // Clear works even with counting off

endmodule

// File: rtl/branchCounter.sv
`timescale 1ns/10ps

module branchCounter (
    input  logic            clk,
    input  logic            rst,
    input  logic            clearCounts,
    input  logic            evBranchExec,
    input  logic            evBranchMiss,
    output perfPkg::counterT totalBranches,
    output perfPkg::counterT mispredictedBranches
);

    logic countMispredict;

    // A mispredict without an executed branch is noise from the core
    assign countMispredict = evBranchExec & evBranchMiss;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            totalBranches        <= '0;
            mispredictedBranches <= '0;
        end else if (clearCounts) begin  // Clear beats any event this cycle
            totalBranches        <= '0;
            mispredictedBranches <= '0;
        end else begin
            if (evBranchExec) begin
                totalBranches <= totalBranches + 32'd1;
            end
            if (countMispredict) begin
                mispredictedBranches <= mispredictedBranches + 32'd1;
            end
        end
    end

endmodule

// File: rtl/cacheCounter.sv
`timescale 1ns/10ps

module cacheCounter (
    input  logic            clk,
    input  logic            rst,
    input  logic            clearCounts,
    input  logic            evCacheMiss,
    input  logic            evCacheStart,
    input  logic            evCacheEnd,
    output perfPkg::counterT countMiss,
    output perfPkg::counterT countAccess,
    output perfPkg::counterT countTimer
);

    import perfPkg::*;

    cacheStateT state;
    cacheStateT nextState;
    logic       timerTick;

    // End has the last word when start and end arrive together
    always_comb begin
        nextState = state;
        if (evCacheStart) begin
            nextState = Counting;
        end
        if (evCacheEnd) begin
            nextState = Idle;
        end
    end

    // Start cycle ticks too but never more than once
    assign timerTick = evCacheStart | (state == Counting);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= Idle;
        end else if (clearCounts) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            countMiss   <= '0;
            countAccess <= '0;
            countTimer  <= '0;
        end else if (clearCounts) begin
            countMiss   <= '0;
            countAccess <= '0;
            countTimer  <= '0;
        end else begin
            if (evCacheMiss) begin
                countMiss <= countMiss + 32'd1;  // Independent of the access state
            end
            if (evCacheStart) begin
                countAccess <= countAccess + 32'd1;
            end
            if (timerTick) begin
                countTimer <= countTimer + 32'd1;
            end
        end
    end

endmodule

// File: rtl/perfReadout.sv
`timescale 1ns/10ps

module perfReadout (
    input  logic              clk,
    input  logic              rst,
    input  perfPkg::counterT  totalBranches,
    input  perfPkg::counterT  mispredictedBranches,
    input  perfPkg::counterT  countMiss,
    input  perfPkg::counterT  countAccess,
    input  perfPkg::counterT  countTimer,
    input  logic              rdEn,
    input  perfPkg::perfAddrT rdAddr,
    output perfPkg::counterT  rdData,
    output logic              rdValid
);

    import perfPkg::*;

    counterT cacheHits;
    counterT selData;

    // Wraps when misses run ahead of accesses
    assign cacheHits = countAccess - countMiss;

    always_comb begin
        case (rdAddr)
            AddrTotalBranches: selData = totalBranches;
            AddrMispredicted:  selData = mispredictedBranches;
            AddrCacheMiss:     selData = countMiss;
            AddrCacheAccess:   selData = countAccess;
            AddrCacheTimer:    selData = countTimer;
            AddrCacheHit:      selData = cacheHits;
            default:           selData = '0;  // Unmapped slots
        endcase
    end

    // Counters seen here are the values before this edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdData <= '0;
        end else if (rdEn) begin
            rdData <= selData;  // Holds until the next read
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= rdEn;  // One pulse per request
        end
    end

endmodule

// File: rtl/perfMonitor.sv
`timescale 1ns/10ps

module perfMonitor (
    input  logic              clk,
    input  logic              rst,
    input  logic              branchExecuted,
    input  logic              branchMispredict,
    input  logic              cacheMiss,
    input  logic              cacheStart,
    input  logic              cacheEnd,
    input  logic              countEnable,
    input  logic              clear,
    input  logic              rdEn,
    input  perfPkg::perfAddrT rdAddr,
    output perfPkg::counterT  rdData,
    output logic              rdValid
);

    import perfPkg::*;

    // Qualified strobes out of capture
    logic evBranchExec;
    logic evBranchMiss;
    logic evCacheMiss;
    logic evCacheStart;
    logic evCacheEnd;
    logic clearCounts;

    counterT totalBranches;
    counterT mispredictedBranches;
    counterT countMiss;
    counterT countAccess;
    counterT countTimer;

    perfEventCapture capture (
        .clk              (clk),
        .rst              (rst),
        .branchExecuted   (branchExecuted),
        .branchMispredict (branchMispredict),
        .cacheMiss        (cacheMiss),
        .cacheStart       (cacheStart),
        .cacheEnd         (cacheEnd),
        .countEnable      (countEnable),
        .clear            (clear),
        .evBranchExec     (evBranchExec),
        .evBranchMiss     (evBranchMiss),
        .evCacheMiss      (evCacheMiss),
        .evCacheStart     (evCacheStart),
        .evCacheEnd       (evCacheEnd),
        .clearCounts      (clearCounts)
    );

    branchCounter branches (
        .clk                  (clk),
        .rst                  (rst),
        .clearCounts          (clearCounts),
        .evBranchExec         (evBranchExec),
        .evBranchMiss         (evBranchMiss),
        .totalBranches        (totalBranches),
        .mispredictedBranches (mispredictedBranches)
    );

    cacheCounter cache (
        .clk          (clk),
        .rst          (rst),
        .clearCounts  (clearCounts),
        .evCacheMiss  (evCacheMiss),
        .evCacheStart (evCacheStart),
        .evCacheEnd   (evCacheEnd),
        .countMiss    (countMiss),
        .countAccess  (countAccess),
        .countTimer   (countTimer)
    );

    // Registered read port, one cycle latency
    perfReadout readout (
        .clk                  (clk),
        .rst                  (rst),
        .totalBranches        (totalBranches),
        .mispredictedBranches (mispredictedBranches),
        .countMiss            (countMiss),
        .countAccess          (countAccess),
        .countTimer           (countTimer),
        .rdEn                 (rdEn),
        .rdAddr               (rdAddr),
        .rdData               (rdData),
        .rdValid              (rdValid)
    );

endmodule

// File: verification/perfMonitor_assertions.sv
`timescale 1ns/10ps

module perfMonitor_assertions (
    input logic             clk,
    input logic             rst,
    input logic             rdEn,
    input logic             rdValid,
    input logic             evBranchExec,
    input logic             evBranchMiss,
    input logic             evCacheMiss,
    input logic             evCacheStart,
    input logic             evCacheEnd,
    input logic             clearCounts,
    input perfPkg::counterT totalBranches,
    input perfPkg::counterT mispredictedBranches,
    input perfPkg::counterT countMiss,
    input perfPkg::counterT countAccess
);

    logic anyEvent;

    assign anyEvent = evBranchExec | evBranchMiss | evCacheMiss | evCacheStart
                    | evCacheEnd | clearCounts;

    validFollowsRead: assert property (
        @(posedge clk) disable iff (rst) rdValid == $past(rdEn)
    ) else $error("rdValid is not the read request of the previous cycle");

    // Sampled away from the rising edge so the async reset has settled
    validLowInReset: assert property (
        @(negedge clk) rst |-> !rdValid
    ) else $error("rdValid is high during reset");

    // Timer left out, it keeps ticking while the cache is busy
    countersHoldWithoutEvent: assert property (
        @(posedge clk) disable iff (rst)
        !anyEvent |=> $stable(totalBranches) && $stable(mispredictedBranches)
                      && $stable(countMiss) && $stable(countAccess)
    ) else $error("A counter changed without an event or a clear");

endmodule

// File: verification/perfMonitorTb.sv
`timescale 1ns/10ps

module perfMonitorTb;

    import perfPkg::*;

    localparam int ClkPeriod    = 4;
    localparam int RandomCycles = 200;
    localparam int NumRows      = 21;

    // Row layout {branchExec, branchMispredict, cacheMiss, cacheStart, cacheEnd, en, clear, check}
    localparam logic [7:0] StimRows [NumRows] = '{
        8'b00000_1_0_1,  // Fresh after reset
        8'b10000_1_0_0,  // Executed branch
        8'b11000_1_0_0,  // Executed and mispredicted
        8'b01000_1_0_0,  // Lone mispredict, ignored
        8'b11000_1_0_1,
        8'b00010_1_0_0,  // Access starts
        8'b00100_1_0_0,  // Miss while busy
        8'b00010_1_0_0,  // Start while already counting
        8'b00001_1_0_0,
        8'b00011_1_0_0,  // Start and end together end up idle
        8'b00100_1_0_1,
        8'b11111_0_0_0,  // Everything masked
        8'b10110_0_0_1,
        8'b11110_1_1_0,  // Clear beats the events
        8'b10010_1_0_0,  // Counting resumes
        8'b00001_1_0_1,
        8'b00100_1_0_0,
        8'b00100_1_0_1,  // More misses than accesses
        8'b00010_1_0_0,
        8'b00100_0_0_0,  // Disabled while the cache is busy
        8'b00001_1_0_1
    };

    logic              clk;
    logic              rst;
    logic              branchExecuted;
    logic              branchMispredict;
    logic              cacheMiss;
    logic              cacheStart;
    logic              cacheEnd;
    logic              countEnable;
    logic              clear;
    logic              rdEn;
    perfAddrT          rdAddr;
    counterT           rdData;
    logic              rdValid;

    // Reference model, index 0..4 is branches, mispredicts, misses, accesses, timer
    counterT mdlCount [5];
    counterT histPrev [5];  // Model one cycle back
    counterT histOld  [5];  // Two cycles back, what a read sees
    logic    mdlBusy;

    logic     pendingValid;
    counterT  pendingData;
    perfAddrT pendingAddr;
    counterT  heldData;
    int       seed;

    perfMonitor dut (
        .clk              (clk),
        .rst              (rst),
        .branchExecuted   (branchExecuted),
        .branchMispredict (branchMispredict),
        .cacheMiss        (cacheMiss),
        .cacheStart       (cacheStart),
        .cacheEnd         (cacheEnd),
        .countEnable      (countEnable),
        .clear            (clear),
        .rdEn             (rdEn),
        .rdAddr           (rdAddr),
        .rdData           (rdData),
        .rdValid          (rdValid)
    );

    bind perfMonitor perfMonitor_assertions assertions (
        .clk                  (clk),
        .rst                  (rst),
        .rdEn                 (rdEn),
        .rdValid              (rdValid),
        .evBranchExec         (evBranchExec),
        .evBranchMiss         (evBranchMiss),
        .evCacheMiss          (evCacheMiss),
        .evCacheStart         (evCacheStart),
        .evCacheEnd           (evCacheEnd),
        .clearCounts          (clearCounts),
        .totalBranches        (totalBranches),
        .mispredictedBranches (mispredictedBranches),
        .countMiss            (countMiss),
        .countAccess          (countAccess)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic checkCounter(input counterT actual, input counterT expected, input string what);
        if (actual !== expected) begin
            abortRun($sformatf("Error at %0t ns: %s is %h, expected %h",
                $time, what, actual, expected));
        end
    endtask

    task automatic checkValid(input logic actual, input logic expected);
        if (actual !== expected) begin
            abortRun($sformatf("Error at %0t ns: rdValid is %b, expected %b",
                $time, actual, expected));
        end
    endtask

    // Counting rules applied to one cycle of inputs
    task automatic applyModel(input logic [4:0] strobes, input logic en, input logic clr);
        logic evExec;
        logic evMispredict;
        logic evMiss;
        logic evStart;
        logic evEnd;
        int   i;
        evExec       = strobes[4] & en;
        evMispredict = strobes[3] & en;
        evMiss       = strobes[2] & en;
        evStart      = strobes[1] & en;
        evEnd        = strobes[0] & en;
        if (clr) begin
            for (i = 0; i < 5; i++) begin
                mdlCount[i] = '0;
            end
            mdlBusy = 1'b0;
        end else begin
            if (evExec) mdlCount[0] = mdlCount[0] + 32'd1;
            if (evExec && evMispredict) mdlCount[1] = mdlCount[1] + 32'd1;
            if (evMiss) mdlCount[2] = mdlCount[2] + 32'd1;
            if (evStart) mdlCount[3] = mdlCount[3] + 32'd1;
            if (evStart || mdlBusy) mdlCount[4] = mdlCount[4] + 32'd1;
            if (evStart) mdlBusy = 1'b1;
            if (evEnd) mdlBusy = 1'b0;  // End wins
        end
    endtask

    function automatic counterT expectedValue(input perfAddrT addr);
        case (addr)
            AddrTotalBranches: return histOld[0];
            AddrMispredicted:  return histOld[1];
            AddrCacheMiss:     return histOld[2];
            AddrCacheAccess:   return histOld[3];
            AddrCacheTimer:    return histOld[4];
            AddrCacheHit:      return histOld[3] - histOld[2];
            default:           return '0;
        endcase
    endfunction

    // One clock of stimulus, checks the read issued one cycle earlier
    task automatic driveCycle(input logic [4:0] strobes, input logic en, input logic clr,
                              input logic rd, input perfAddrT addr);
        counterT expData;
        @(posedge clk);
        {branchExecuted, branchMispredict, cacheMiss, cacheStart, cacheEnd} <= strobes;
        countEnable <= en;
        clear       <= clr;
        rdEn        <= rd;
        rdAddr      <= addr;
        histOld  = histPrev;
        histPrev = mdlCount;
        applyModel(strobes, en, clr);
        expData = expectedValue(addr);
        @(negedge clk);
        checkValid(rdValid, pendingValid);
        if (pendingValid) begin
            checkCounter(rdData, pendingData, $sformatf("rdData at address %0d", pendingAddr));
            heldData = pendingData;
        end else begin
            checkCounter(rdData, heldData, "held rdData");
        end
        pendingValid = rd;
        pendingData  = expData;
        pendingAddr  = addr;
    endtask

    task automatic readAll();
        int i;
        driveCycle(5'b00000, 1'b0, 1'b0, 1'b0, '0);
        driveCycle(5'b00000, 1'b0, 1'b0, 1'b0, '0);
        for (i = 0; i < 8; i++) begin
            driveCycle(5'b00000, 1'b0, 1'b0, 1'b1, perfAddrT'(i));
        end
    endtask

    initial begin
        int         r;
        int         rnd;
        logic [7:0] row;
        rst              = 1'b1;
        branchExecuted   = 1'b0;
        branchMispredict = 1'b0;
        cacheMiss        = 1'b0;
        cacheStart       = 1'b0;
        cacheEnd         = 1'b0;
        countEnable      = 1'b0;
        clear            = 1'b0;
        rdEn             = 1'b0;
        rdAddr           = '0;
        for (r = 0; r < 5; r++) begin
            mdlCount[r] = '0;
            histPrev[r] = '0;
            histOld[r]  = '0;
        end
        mdlBusy      = 1'b0;
        pendingValid = 1'b0;
        pendingData  = '0;
        pendingAddr  = '0;
        heldData     = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (r = 0; r < NumRows; r++) begin
            row = StimRows[r];
            driveCycle(row[7:3], row[2], row[1], 1'b0, '0);
            if (row[0]) begin
                readAll();
            end
        end

        seed = 32'h89a6;
        repeat (RandomCycles) begin
            rnd = $random(seed);
            driveCycle(rnd[4:0], rnd[7:5] != 3'b000, rnd[15:10] == 6'd0, 1'b0, '0);
        end
        readAll();
        driveCycle(5'b00000, 1'b0, 1'b0, 1'b0, '0);  // Flush the last read

        $display("Done: no errors");
        $finish;
    end

    initial begin
        int checks;
        int limitNs;
        int r;
        checks = 1;  // Final read after the random phase
        for (r = 0; r < NumRows; r++) begin
            if (StimRows[r][0]) checks++;
        end
        limitNs = (NumRows + RandomCycles + 20 * checks) * ClkPeriod + 200;
        #(limitNs);
        abortRun("Watchdog timeout: the test sequence did not finish in time");
    end

endmodule

// File: sim.f
rtl/perfPkg.sv
rtl/perfEventCapture.sv
rtl/branchCounter.sv
rtl/cacheCounter.sv
rtl/perfReadout.sv
rtl/perfMonitor.sv
verification/perfMonitor_assertions.sv
verification/perfMonitorTb.sv

// File: Makefile
# Verilator build for the performance monitor testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR   ?= verilator
TOP         ?= perfMonitorTb
FILELIST    ?= sim.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing --assert -j 0
EXTRA_FLAGS ?=
SIM_ARGS    ?=

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status here
run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
